// ==== design/calc_cfg_pkg.sv ====
// Sizes and latencies of the calculator datapath
package calc_cfg_pkg;

    // Job queue between key entry and executor
    localparam int JOB_FIFO_DEPTH = 4;             // Entries in the job FIFO
    localparam int JOB_PTR_W      = 2;             // Read and write pointer width
    localparam int JOB_CNT_W      = JOB_PTR_W + 1; // Occupancy counter, holds 0..DEPTH

    // Sequential multiplier
    localparam int MULT_STEPS  = 16;                  // One iteration per multiplier bit
    localparam int MULT_CNT_W  = $clog2(MULT_STEPS);  // Iteration counter width

endpackage

// ==== design/calc_types_pkg.sv ====
// Data types and operator codes shared by entry, queue and executor
package calc_types_pkg;

    // Keypad and operand widths
    typedef logic [3:0]  digit_t;    // One decimal key, 0..9
    typedef logic [15:0] operand_t;  // Unsigned entered operand, wraps mod 2^16

    // Value shown on the display
    typedef logic signed [15:0] result_t;  // Two's complement result

    // One-hot operator select from the keypad
    typedef logic [2:0] op_code_t;

    localparam op_code_t OP_ADD = 3'b001;  // Addition
    localparam op_code_t OP_SUB = 3'b010;  // Subtraction, a minus b
    localparam op_code_t OP_MUL = 3'b100;  // Multiplication, low 16 bits kept

endpackage

// ==== design/job_if.sv ====
`timescale 1ns/1ps

// One calculation job, from producer through queue to consumer
interface job_if;
    import calc_types_pkg::*;

    logic     valid;  // Strobe on the write side, non-empty on the read side
    operand_t a;      // First operand
    operand_t b;      // Second operand
    op_code_t op;     // One-hot operator
    logic     pop;    // Consumer takes the head entry

    // Key entry pushes jobs
    modport source (output valid, a, b, op);

    // FIFO write side
    modport sink_wr (input valid, a, b, op);

    // FIFO read side, show-ahead head
    modport sink_rd (output valid, a, b, op, input pop);

    // Executor pops the head
    modport exec (input valid, a, b, op, output pop);

endinterface

// ==== design/key_entry.sv ====
`timescale 1ns/1ps

module key_entry (
    input  logic                      clk,
    input  logic                      nRST,
    input  calc_types_pkg::digit_t    keypad_input,    // Current key digit
    input  logic                      read_input,      // Take keypad_input this cycle
    input  calc_types_pkg::op_code_t  operator_input,  // One-hot operator key
    input  logic                      equal_input,     // Issue the job
    job_if.source                     job
);
    import calc_types_pkg::*;

    typedef enum logic {
        GET_A,  // Entering first operand
        GET_B   // Entering second operand
    } entry_state_t;

    entry_state_t state;

    operand_t a_acc;   // First operand under entry
    operand_t b_acc;   // Second operand under entry
    op_code_t op_reg;  // Latched operator

    logic op_legal;
    logic issue;

    // Ten times the old value plus the digit, built from two shifts
    function automatic operand_t mul10_add(operand_t value, digit_t digit);
        return (value << 3) + (value << 1) + operand_t'(digit);
    endfunction

    assign op_legal = (operator_input == OP_ADD) ||
                      (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    assign issue = (state == GET_B) && equal_input;  // Equal only counts after an operator

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= GET_A;
            a_acc     <= '0;
            b_acc     <= '0;
            op_reg    <= OP_ADD;
            job.valid <= 1'b0;
        end else begin
            job.valid <= issue;  // Single-cycle strobe, never refused
            case (state)
                GET_A: begin
                    if (read_input) begin
                        a_acc <= mul10_add(a_acc, keypad_input);
                    end
                    if (op_legal) begin
                        op_reg <= operator_input;  // Illegal codes fall through
                        state  <= GET_B;
                    end
                end
                GET_B: begin
                    if (equal_input) begin
                        // Job is captured below, start over for the next one
                        a_acc <= '0;
                        b_acc <= '0;
                        state <= GET_A;
                    end else if (read_input) begin
                        b_acc <= mul10_add(b_acc, keypad_input);
                    end
                end
                default: state <= GET_A;
            endcase
        end
    end

    // Job payload, valid alongside the strobe
    always_ff @(posedge clk) begin
        if (issue) begin
            job.a  <= a_acc;
            job.b  <= b_acc;
            job.op <= op_reg;
        end
    end

endmodule

// ==== design/job_fifo.sv ====
`timescale 1ns/1ps

module job_fifo (
    input  logic    clk,
    input  logic    nRST,
    job_if.sink_wr  wr,        // Pushes from key entry
    job_if.sink_rd  rd,        // Head to the executor
    output logic    overflow   // One-cycle pulse per dropped job
);
    import calc_cfg_pkg::*;
    import calc_types_pkg::*;

    // Job storage
    operand_t mem_a  [JOB_FIFO_DEPTH];
    operand_t mem_b  [JOB_FIFO_DEPTH];
    op_code_t mem_op [JOB_FIFO_DEPTH];

    logic [JOB_PTR_W-1:0] wr_ptr;
    logic [JOB_PTR_W-1:0] rd_ptr;
    logic [JOB_CNT_W-1:0] count;

    logic full;
    logic do_push;
    logic do_pop;

    assign full    = (count == JOB_CNT_W'(JOB_FIFO_DEPTH));
    assign do_pop  = rd.pop && (count != '0);
    assign do_push = wr.valid && (!full || do_pop);  // Pop frees the slot when full

    // Show-ahead head
    assign rd.valid = (count != '0);
    assign rd.a     = mem_a[rd_ptr];
    assign rd.b     = mem_b[rd_ptr];
    assign rd.op    = mem_op[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_a[wr_ptr]  <= wr.a;
            mem_b[wr_ptr]  <= wr.b;
            mem_op[wr_ptr] <= wr.op;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= wr.valid && !do_push;  // Dropped push
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// ==== design/shift_add_mult.sv ====
`timescale 1ns/1ps

module shift_add_mult (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic                      start,         // Load operands, first step
    input  calc_types_pkg::operand_t  multiplicand,
    input  calc_types_pkg::operand_t  multiplier,
    output calc_types_pkg::operand_t  product,       // Low 16 bits of the product
    output logic                      done           // Product ready, one cycle
);
    import calc_cfg_pkg::*;
    import calc_types_pkg::*;

    typedef enum logic {
        M_IDLE,
        M_RUN
    } mult_state_t;

    mult_state_t state;

    logic [MULT_CNT_W-1:0] step;  // Iterations already taken

    operand_t mcand_q;   // Multiplicand, shifted left per step
    operand_t mplier_q;  // Multiplier, shifted right per step
    operand_t acc_q;     // Partial product

    operand_t src_mcand;
    operand_t src_mplier;
    operand_t src_acc;
    logic     advance;

    // First iteration runs on the start edge straight from the inputs
    assign src_mcand  = (state == M_IDLE) ? multiplicand : mcand_q;
    assign src_mplier = (state == M_IDLE) ? multiplier   : mplier_q;
    assign src_acc    = (state == M_IDLE) ? '0           : acc_q;
    assign advance    = (state == M_RUN) || start;

    assign product = acc_q;

    always_ff @(posedge clk) begin
        if (advance) begin
            acc_q    <= src_acc + (src_mplier[0] ? src_mcand : '0);  // Carry out dropped
            mcand_q  <= src_mcand << 1;
            mplier_q <= src_mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= M_IDLE;
            step  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (start) begin
                        step  <= MULT_CNT_W'(1);
                        state <= M_RUN;
                    end
                end
                M_RUN: begin
                    step <= step + 1'b1;
                    if (step == MULT_CNT_W'(MULT_STEPS - 1)) begin
                        done  <= 1'b1;  // Last step lands on this edge
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

// ==== design/calc_exec.sv ====
`timescale 1ns/1ps

module calc_exec (
    input  logic                     clk,
    input  logic                     nRST,
    job_if.exec                      job,
    output logic                     complete,        // One cycle per finished job
    output calc_types_pkg::result_t  display_output   // Held until the next result
);
    import calc_types_pkg::*;

    typedef enum logic {
        EX_IDLE,  // Waiting for a job
        EX_MULT   // Multiplier busy
    } exec_state_t;

    exec_state_t state;

    logic     take;        // Head taken this cycle
    logic     mult_start;
    logic     mult_done;
    operand_t mult_product;

    assign take       = (state == EX_IDLE) && job.valid;
    assign job.pop    = take;
    assign mult_start = take && (job.op == OP_MUL);

    shift_add_mult u_mult (
        .clk          (clk),
        .nRST         (nRST),
        .start        (mult_start),
        .multiplicand (job.a),
        .multiplier   (job.b),
        .product      (mult_product),
        .done         (mult_done)
    );

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= EX_IDLE;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            complete <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (take) begin
                        case (job.op)
                            OP_ADD: begin
                                display_output <= result_t'(job.a + job.b);
                                complete       <= 1'b1;
                            end
                            OP_SUB: begin
                                // Wraps to a negative value when b exceeds a
                                display_output <= result_t'(job.a - job.b);
                                complete       <= 1'b1;
                            end
                            OP_MUL: state <= EX_MULT;  // Multiplier already started
                            default: ;                 // Not produced by key entry
                        endcase
                    end
                end
                EX_MULT: begin
                    if (mult_done) begin
                        display_output <= result_t'(mult_product);
                        complete       <= 1'b1;
                        state          <= EX_IDLE;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

endmodule

// ==== design/calc_top.sv ====
`timescale 1ns/1ps

module calc_top (
    input  logic                      clk,
    input  logic                      nRST,
    input  calc_types_pkg::digit_t    keypad_input,    // Decimal key value
    input  logic                      read_input,      // Digit strobe
    input  calc_types_pkg::op_code_t  operator_input,  // One-hot operator key
    input  logic                      equal_input,     // Equal key strobe
    output logic                      complete,        // Result valid pulse
    output calc_types_pkg::result_t   display_output,  // Signed result
    output logic                      overflow         // Job dropped, FIFO full
);

    job_if entry_job ();  // Key entry to FIFO
    job_if fifo_job ();   // FIFO head to executor

    key_entry u_entry (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .job            (entry_job)
    );

    job_fifo u_fifo (
        .clk      (clk),
        .nRST     (nRST),
        .wr       (entry_job),
        .rd       (fifo_job),
        .overflow (overflow)
    );

    calc_exec u_exec (
        .clk            (clk),
        .nRST           (nRST),
        .job            (fifo_job),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

// ==== tests/calc_assert.sv ====
`timescale 1ns/1ps

module calc_assert (
    input logic clk,
    input logic nRST,
    input logic complete,
    input logic overflow,
    input logic pop,
    input logic head_valid
);

    // One result pulse per job
    property complete_single;
        @(posedge clk) disable iff (!nRST) complete |=> !complete;
    endproperty

    property quiet_in_reset;
        @(posedge clk) !nRST |-> (!complete && !overflow);
    endproperty

    // A queued job leaves the head only through a pop
    property head_held_until_pop;
        @(posedge clk) disable iff (!nRST) (head_valid && !pop) |=> head_valid;
    endproperty

    a_complete_single: assert property (complete_single)
        else $error("complete held high for two cycles");

    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("complete or overflow high during reset");

    a_head_held_until_pop: assert property (head_held_until_pop)
        else $error("FIFO head lost without a pop");

endmodule

bind calc_top calc_assert u_assert (
    .clk        (clk),
    .nRST       (nRST),
    .complete   (complete),
    .overflow   (overflow),
    .pop        (fifo_job.pop),
    .head_valid (fifo_job.valid)
);

// ==== tests/calc_tb.sv ====
`timescale 1ns/1ps

module calc_tb;
    import calc_types_pkg::*;
    import calc_cfg_pkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int BURST_JOBS      = 12;
    localparam int TOTAL_JOBS      = 3 + 2 + 3 + 1 + BURST_JOBS + 3;
    localparam int CYCLES_PER_JOB  = 40;  // Entry, queueing and a full multiply
    localparam int WATCHDOG_CYCLES = TOTAL_JOBS * CYCLES_PER_JOB + RESET_CYCLES + 200;

    logic     clk;
    logic     nRST;
    digit_t   keypad_input;
    logic     read_input;
    op_code_t operator_input;
    logic     equal_input;
    logic     complete;
    result_t  display_output;
    logic     overflow;

    result_t exp_q[$];  // Expected results in job order
    result_t exp_val;
    bit      matched;
    bit      burst_mode;   // Dropped jobs allowed, match a subsequence
    integer  seed;
    int      errors;
    int      results;
    int      overflow_count;
    int      jobs_issued;

    calc_top dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output),
        .overflow       (overflow)
    );

    always #5 clk = ~clk;

    // Expected display value, everything wraps mod 2^16
    function automatic result_t calc_ref(operand_t a, operand_t b, op_code_t op);
        logic [31:0] wide;
        case (op)
            OP_ADD:  wide = {16'd0, a} + {16'd0, b};
            OP_SUB:  wide = {16'd0, a} - {16'd0, b};  // Negative when b exceeds a
            OP_MUL:  wide = {16'd0, a} * {16'd0, b};
            default: wide = '0;
        endcase
        return result_t'(wide[15:0]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t",
                     name, got, expected, $time);
        end
    endtask

    // Decimal digits, most significant first, one per cycle
    task automatic enter_number(input int unsigned value, output operand_t entered);
        int unsigned digits[$];
        int unsigned v;
        int unsigned acc;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v != 0);
        acc = 0;
        foreach (digits[i]) begin
            keypad_input = digit_t'(digits[i]);
            read_input   = 1'b1;
            @(negedge clk);
            acc = (acc * 10 + digits[i]) % 65536;  // Low 16 bits kept on entry
        end
        read_input   = 1'b0;
        keypad_input = '0;
        entered      = operand_t'(acc);
    endtask

    task automatic pulse_operator(input op_code_t op);
        operator_input = op;
        @(negedge clk);
        operator_input = '0;
    endtask

    task automatic pulse_equal();
        equal_input = 1'b1;
        @(negedge clk);
        equal_input = 1'b0;
    endtask

    task automatic run_job(input int unsigned a_val, input int unsigned b_val,
                           input op_code_t op);
        operand_t a_w;
        operand_t b_w;
        enter_number(a_val, a_w);
        pulse_operator(op);
        enter_number(b_val, b_w);
        pulse_equal();
        exp_q.push_back(calc_ref(a_w, b_w, op));
        jobs_issued++;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // Cycles from head valid to complete, executor idle beforehand
    task automatic measure_mult_latency(input int unsigned a_val, input int unsigned b_val);
        int cyc;
        int t_valid;
        int t_done;
        run_job(a_val, b_val, OP_MUL);
        cyc     = 0;
        t_valid = -1;
        t_done  = -1;
        while (t_done < 0) begin
            @(negedge clk);
            cyc++;
            if (t_valid < 0 && dut.fifo_job.valid) t_valid = cyc;
            if (complete) t_done = cyc;
        end
        check_value("mult_latency", t_done - t_valid, MULT_STEPS + 1);
        wait_results();
    endtask

    // Result compare, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (nRST && complete) begin
            results++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: complete seen with no job outstanding at %0t", $time);
            end else if (burst_mode) begin
                matched = 1'b0;
                while (!matched && exp_q.size() != 0) begin
                    exp_val = exp_q.pop_front();
                    matched = (exp_val == display_output);  // Skip dropped jobs
                end
                if (!matched) begin
                    errors++;
                    $display("ERROR: burst result 0x%0h matches no later job at %0t",
                             display_output, $time);
                end
            end else begin
                exp_val = exp_q.pop_front();
                check_value("display_output", display_output, exp_val);
            end
        end
    end

    always @(negedge clk) begin
        if (nRST && overflow) overflow_count++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        int base_results;
        int base_overflows;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        burst_mode     = 1'b0;
        seed           = 32'h64d1ea92;
        errors         = 0;
        results        = 0;
        overflow_count = 0;
        jobs_issued    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);

        // Addition, multi-digit operands
        run_job(12, 345, OP_ADD);
        wait_results();
        run_job(99999, 1, OP_ADD);  // First operand wraps on entry
        wait_results();
        run_job(65535, 7, OP_ADD);
        wait_results();

        // Subtraction going negative
        run_job(3, 250, OP_SUB);
        wait_results();
        run_job(17, 60000, OP_SUB);
        wait_results();

        // Multiplication with latency check
        measure_mult_latency(255, 255);
        measure_mult_latency(1234, 567);
        measure_mult_latency(65535, 65535);

        // Illegal operators and an early equal do nothing
        pulse_equal();
        pulse_operator(3'b011);
        pulse_operator(3'b111);
        pulse_operator(3'b110);
        repeat (5) @(negedge clk);
        run_job(42, 8, OP_SUB);
        wait_results();

        // Back to back one-digit multiplies overrun the FIFO
        base_results   = results;
        base_overflows = overflow_count;
        burst_mode     = 1'b1;
        for (int i = 0; i < BURST_JOBS; i++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            run_job(rnd_a % 10, rnd_b % 10, OP_MUL);
        end
        while ((results - base_results) + (overflow_count - base_overflows) < BURST_JOBS)
            @(negedge clk);
        repeat (20) @(negedge clk);  // Nothing extra may arrive
        check_value("burst_results_plus_overflows",
                    (results - base_results) + (overflow_count - base_overflows),
                    BURST_JOBS);
        burst_mode = 1'b0;
        exp_q.delete();

        // Reset while a multiply runs
        run_job(300, 200, OP_MUL);
        repeat (5) @(negedge clk);
        nRST = 1'b0;
        exp_q.delete();  // Job is lost
        repeat (3) @(negedge clk);
        nRST = 1'b1;
        repeat (30) @(negedge clk);
        run_job(7, 8, OP_ADD);
        wait_results();
        run_job(21, 3, OP_MUL);
        wait_results();

        $display("Summary: %0d errors, %0d jobs issued, %0d results, %0d overflow pulses",
                 errors, jobs_issued, results, overflow_count);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/calc_cfg_pkg.sv
design/calc_types_pkg.sv
design/job_if.sv
design/key_entry.sv
design/job_fifo.sv
design/shift_add_mult.sv
design/calc_exec.sv
design/calc_top.sv
tests/calc_assert.sv
tests/calc_tb.sv

// ==== Bender.yml ====
package:
  name: calc

sources:
  # Packages first, then interface and RTL in dependency order
  - design/calc_cfg_pkg.sv
  - design/calc_types_pkg.sv
  - design/job_if.sv
  - design/key_entry.sv
  - design/job_fifo.sv
  - design/shift_add_mult.sv
  - design/calc_exec.sv
  - design/calc_top.sv
  - target: test
    files:
      - tests/calc_assert.sv
      - tests/calc_tb.sv
